//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it, the exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tb_soc_periph -o sim_tb &&
./obj_dir/sim_tb || exit 1

//--- source/apb_gpio.sv
// APB GPIO controller with input synchronizer and rising-edge interrupts
`default_nettype none

module apb_gpio #(
  parameter int GPIO_WIDTH = soc_periph_pkg::GPIO_WIDTH_DEFAULT
)
(
  input wire i_sys_clk,
  input wire i_arst_n,
  // Slot bus
  input wire i_sel,
  input wire i_penable,
  input wire i_pwrite,
  input wire [soc_periph_pkg::SLOT_OFF_W-1:0] i_addr,
  input wire [soc_periph_pkg::APB_DATA_W-1:0] i_wdata,
  output logic [soc_periph_pkg::APB_DATA_W-1:0] o_rdata,
  output logic o_err,
  // Pins
  input wire [GPIO_WIDTH-1:0] i_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio_dir,
  // One-cycle pulse per bit
  output logic [GPIO_WIDTH-1:0] o_irq
);

  logic [GPIO_WIDTH-1:0] mask_q;
  logic [GPIO_WIDTH-1:0] sync1_q;
  logic [GPIO_WIDTH-1:0] sync2_q;
  logic [GPIO_WIDTH-1:0] prev_q;
  logic wr_en;
  logic off_ok;

  assign wr_en = i_sel & i_penable & i_pwrite;

  //////////////////////////////
  // Register read and decode
  //////////////////////////////
  always_comb
  begin
    o_rdata = '0;
    off_ok = 1'b1;
    case (i_addr)
      soc_periph_pkg::GPIO_DIR:      o_rdata[GPIO_WIDTH-1:0] = o_gpio_dir;
      soc_periph_pkg::GPIO_OUT:      o_rdata[GPIO_WIDTH-1:0] = o_gpio;
      // Synchronized pin value, not the raw input
      soc_periph_pkg::GPIO_IN:       o_rdata[GPIO_WIDTH-1:0] = sync2_q;
      soc_periph_pkg::GPIO_IRQ_MASK: o_rdata[GPIO_WIDTH-1:0] = mask_q;
      default:                       off_ok = 1'b0;
    endcase
  end

  assign o_err = i_sel & i_penable & ~off_ok;

  // Register writes land on the completing edge
  always_ff @(posedge i_sys_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_gpio_dir <= '0;
      o_gpio <= '0;
      mask_q <= '0;
    end
    else if (wr_en)
    begin
      case (i_addr)
        soc_periph_pkg::GPIO_DIR:      o_gpio_dir <= i_wdata[GPIO_WIDTH-1:0];
        soc_periph_pkg::GPIO_OUT:      o_gpio <= i_wdata[GPIO_WIDTH-1:0];
        soc_periph_pkg::GPIO_IRQ_MASK: mask_q <= i_wdata[GPIO_WIDTH-1:0];
        // GPIO_IN is read-only
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Input path
  //////////////////////////////
  // Two flops for metastability, a third keeps the previous sample
  always_ff @(posedge i_sys_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q <= '0;
      o_irq <= '0;
    end
    else
    begin
      sync1_q <= i_gpio;
      sync2_q <= sync1_q;
      prev_q <= sync2_q;
      // Rising edge on a masked bit
      o_irq <= sync2_q & ~prev_q & mask_q;
    end
  end

endmodule

`default_nettype wire

//--- source/apb_pnp.sv
// Plug-and-play block with read-only identification and configuration words
`default_nettype none

module apb_pnp #(
  parameter int GPIO_WIDTH = soc_periph_pkg::GPIO_WIDTH_DEFAULT
)
(
  input wire i_sel,
  input wire i_penable,
  input wire i_pwrite,
  input wire [soc_periph_pkg::SLOT_OFF_W-1:0] i_addr,
  output logic [soc_periph_pkg::APB_DATA_W-1:0] o_rdata,
  output logic o_err
);

  localparam int CFG_SLOTS = soc_periph_pkg::SLOT_TOTAL;

  // Slot count in the low byte, GPIO width above it
  localparam logic [7:0] CFG_SLOTS_B = CFG_SLOTS[7:0];
  localparam logic [7:0] CFG_GPIO_B = GPIO_WIDTH[7:0];

  // Device id words, one per slot starting at DEV_BASE
  localparam logic [soc_periph_pkg::SLOT_OFF_W-1:0] DEV_GPIO_OFF =
      soc_periph_pkg::PNP_DEV_BASE + 10'(4 * soc_periph_pkg::SLOT_GPIO);
  localparam logic [soc_periph_pkg::SLOT_OFF_W-1:0] DEV_IRQ_OFF =
      soc_periph_pkg::PNP_DEV_BASE + 10'(4 * soc_periph_pkg::SLOT_IRQ);
  localparam logic [soc_periph_pkg::SLOT_OFF_W-1:0] DEV_PNP_OFF =
      soc_periph_pkg::PNP_DEV_BASE + 10'(4 * soc_periph_pkg::SLOT_PNP);

  logic off_ok;

  //////////////////////////////
  // Word lookup
  //////////////////////////////
  always_comb
  begin
    o_rdata = '0;
    off_ok = 1'b1;
    case (i_addr)
      soc_periph_pkg::PNP_HWID:   o_rdata = soc_periph_pkg::HW_ID;
      soc_periph_pkg::PNP_CONFIG: o_rdata[15:0] = {CFG_GPIO_B, CFG_SLOTS_B};
      DEV_GPIO_OFF:               o_rdata[15:0] = soc_periph_pkg::DEV_ID_GPIO;
      DEV_IRQ_OFF:                o_rdata[15:0] = soc_periph_pkg::DEV_ID_IRQ;
      DEV_PNP_OFF:                o_rdata[15:0] = soc_periph_pkg::DEV_ID_PNP;
      default:                    off_ok = 1'b0;
    endcase
    // Read-only block, writes get zero data
    if (i_pwrite)
    begin
      o_rdata = '0;
    end
  end

  // Any write, or a read outside the table, is an error
  assign o_err = i_sel & i_penable & (i_pwrite | ~off_ok);

endmodule

`default_nettype wire

//--- source/apb_slot_decoder.sv
// APB slot decoder with slave selects, read data mux and unmapped slot error
`default_nettype none

module apb_slot_decoder
(
  input wire i_psel,
  input wire i_penable,
  input wire [soc_periph_pkg::APB_ADDR_W-1:0] i_paddr,
  // One-hot slave selects
  output logic o_gpio_sel,
  output logic o_irq_sel,
  output logic o_pnp_sel,
  // Slave responses
  input wire [soc_periph_pkg::APB_DATA_W-1:0] i_gpio_rdata,
  input wire i_gpio_err,
  input wire [soc_periph_pkg::APB_DATA_W-1:0] i_irq_rdata,
  input wire i_irq_err,
  input wire [soc_periph_pkg::APB_DATA_W-1:0] i_pnp_rdata,
  input wire i_pnp_err,
  // Response back to the master
  output logic [soc_periph_pkg::APB_DATA_W-1:0] o_prdata,
  output logic o_pready,
  output logic o_pslverr
);

  logic [soc_periph_pkg::SLOT_W-1:0] slot;
  logic slot_err;

  // Slot number from the top address bits
  assign slot = i_paddr[soc_periph_pkg::APB_ADDR_W-1 -: soc_periph_pkg::SLOT_W];

  assign o_gpio_sel = i_psel & (slot == soc_periph_pkg::SLOT_GPIO);
  assign o_irq_sel  = i_psel & (slot == soc_periph_pkg::SLOT_IRQ);
  assign o_pnp_sel  = i_psel & (slot == soc_periph_pkg::SLOT_PNP);

  // No slave stalls, so every access cycle completes
  assign o_pready = i_psel & i_penable;

  //////////////////////////////
  // Response mux
  //////////////////////////////
  always_comb
  begin
    o_prdata = '0;
    slot_err = 1'b0;
    case (slot)
      soc_periph_pkg::SLOT_GPIO:
      begin
        o_prdata = i_gpio_rdata;
        slot_err = i_gpio_err;
      end
      soc_periph_pkg::SLOT_IRQ:
      begin
        o_prdata = i_irq_rdata;
        slot_err = i_irq_err;
      end
      soc_periph_pkg::SLOT_PNP:
      begin
        o_prdata = i_pnp_rdata;
        slot_err = i_pnp_err;
      end
      // Unmapped slot answers with zero data and an error
      default: slot_err = 1'b1;
    endcase
  end

  assign o_pslverr = o_pready & slot_err;

endmodule

`default_nettype wire

//--- source/irq_ctrl.sv
// Reduced PLIC with pending, enable and claim registers over GPIO requests
`default_nettype none

module irq_ctrl #(
  parameter int GPIO_WIDTH = soc_periph_pkg::GPIO_WIDTH_DEFAULT
)
(
  input wire i_sys_clk,
  input wire i_arst_n,
  // Slot bus
  input wire i_sel,
  input wire i_penable,
  input wire i_pwrite,
  input wire [soc_periph_pkg::SLOT_OFF_W-1:0] i_addr,
  input wire [soc_periph_pkg::APB_DATA_W-1:0] i_wdata,
  output logic [soc_periph_pkg::APB_DATA_W-1:0] o_rdata,
  output logic o_err,
  // Request pulses from the GPIO block
  input wire [GPIO_WIDTH-1:0] i_irq_request,
  output logic o_irq
);

  logic [GPIO_WIDTH-1:0] pending_q;
  logic [GPIO_WIDTH-1:0] enable_q;
  logic [GPIO_WIDTH-1:0] active;
  logic [GPIO_WIDTH-1:0] claim_mask;
  logic [GPIO_WIDTH-1:0] clr_mask;
  logic [soc_periph_pkg::APB_DATA_W-1:0] claim_id;
  logic access;
  logic off_ok;
  logic claim_rd;

  assign access = i_sel & i_penable;
  assign active = pending_q & enable_q;
  assign o_irq = |active;

  //////////////////////////////
  // Claim selection
  //////////////////////////////
  // Walk down so the lowest active index wins, id is index plus one
  always_comb
  begin
    claim_mask = '0;
    claim_id = '0;
    for (int i = GPIO_WIDTH - 1; i >= 0; i--)
    begin
      if (active[i])
      begin
        claim_mask = '0;
        claim_mask[i] = 1'b1;
        claim_id = soc_periph_pkg::APB_DATA_W'(i + 1);
      end
    end
  end

  // Register read and decode
  always_comb
  begin
    o_rdata = '0;
    off_ok = 1'b1;
    case (i_addr)
      soc_periph_pkg::IRQ_PENDING: o_rdata[GPIO_WIDTH-1:0] = pending_q;
      soc_periph_pkg::IRQ_ENABLE:  o_rdata[GPIO_WIDTH-1:0] = enable_q;
      soc_periph_pkg::IRQ_CLAIM:   o_rdata = claim_id;
      default:                     off_ok = 1'b0;
    endcase
  end

  assign o_err = access & ~off_ok;
  assign claim_rd = access & ~i_pwrite & (i_addr == soc_periph_pkg::IRQ_CLAIM);

  // Bits dropped this cycle, by write-1-to-clear or by a claim
  always_comb
  begin
    clr_mask = '0;
    if (access && i_pwrite && (i_addr == soc_periph_pkg::IRQ_PENDING))
    begin
      clr_mask = i_wdata[GPIO_WIDTH-1:0];
    end
    if (claim_rd)
    begin
      clr_mask = clr_mask | claim_mask;
    end
  end

  //////////////////////////////
  // State
  //////////////////////////////
  always_ff @(posedge i_sys_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      pending_q <= '0;
      enable_q <= '0;
    end
    else
    begin
      // A new request is never lost to a clear in the same cycle
      pending_q <= (pending_q & ~clr_mask) | i_irq_request;
      if (access && i_pwrite && (i_addr == soc_periph_pkg::IRQ_ENABLE))
      begin
        enable_q <= i_wdata[GPIO_WIDTH-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/soc_periph.sv
// Peripheral subsystem top with APB decoder, GPIO, interrupt controller and PnP
`default_nettype none

module soc_periph #(
  parameter int GPIO_WIDTH = soc_periph_pkg::GPIO_WIDTH_DEFAULT
)
(
  input wire i_sys_clk,
  input wire i_arst_n,
  // APB slave port
  input wire i_psel,
  input wire i_penable,
  input wire i_pwrite,
  input wire [soc_periph_pkg::APB_ADDR_W-1:0] i_paddr,
  input wire [soc_periph_pkg::APB_DATA_W-1:0] i_pwdata,
  output logic [soc_periph_pkg::APB_DATA_W-1:0] o_prdata,
  output logic o_pready,
  output logic o_pslverr,
  // GPIO pins
  input wire [GPIO_WIDTH-1:0] i_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio_dir,
  // Interrupt to the CPU
  output logic o_irq
);

  logic gpio_sel;
  logic irq_sel;
  logic pnp_sel;
  logic [soc_periph_pkg::APB_DATA_W-1:0] gpio_rdata;
  logic [soc_periph_pkg::APB_DATA_W-1:0] irq_rdata;
  logic [soc_periph_pkg::APB_DATA_W-1:0] pnp_rdata;
  logic gpio_err;
  logic irq_err;
  logic pnp_err;
  logic [GPIO_WIDTH-1:0] gpio_irq;

  //////////////////////////////
  // Slot decoder
  //////////////////////////////
  apb_slot_decoder u_dec (
    .i_psel(i_psel),
    .i_penable(i_penable),
    .i_paddr(i_paddr),
    .o_gpio_sel(gpio_sel),
    .o_irq_sel(irq_sel),
    .o_pnp_sel(pnp_sel),
    .i_gpio_rdata(gpio_rdata),
    .i_gpio_err(gpio_err),
    .i_irq_rdata(irq_rdata),
    .i_irq_err(irq_err),
    .i_pnp_rdata(pnp_rdata),
    .i_pnp_err(pnp_err),
    .o_prdata(o_prdata),
    .o_pready(o_pready),
    .o_pslverr(o_pslverr)
  );

  // Slot 0, GPIO
  apb_gpio #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) u_gpio (
    .i_sys_clk(i_sys_clk),
    .i_arst_n(i_arst_n),
    .i_sel(gpio_sel),
    .i_penable(i_penable),
    .i_pwrite(i_pwrite),
    .i_addr(i_paddr[soc_periph_pkg::SLOT_OFF_W-1:0]),
    .i_wdata(i_pwdata),
    .o_rdata(gpio_rdata),
    .o_err(gpio_err),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .o_irq(gpio_irq)
  );

  // Slot 1, interrupt controller fed by the GPIO edge pulses
  irq_ctrl #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) u_irq (
    .i_sys_clk(i_sys_clk),
    .i_arst_n(i_arst_n),
    .i_sel(irq_sel),
    .i_penable(i_penable),
    .i_pwrite(i_pwrite),
    .i_addr(i_paddr[soc_periph_pkg::SLOT_OFF_W-1:0]),
    .i_wdata(i_pwdata),
    .o_rdata(irq_rdata),
    .o_err(irq_err),
    .i_irq_request(gpio_irq),
    .o_irq(o_irq)
  );

  // Slot 2, plug-and-play words
  apb_pnp #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) u_pnp (
    .i_sel(pnp_sel),
    .i_penable(i_penable),
    .i_pwrite(i_pwrite),
    .i_addr(i_paddr[soc_periph_pkg::SLOT_OFF_W-1:0]),
    .o_rdata(pnp_rdata),
    .o_err(pnp_err)
  );

endmodule

`default_nettype wire

//--- source/soc_periph_pkg.sv
// Shared APB widths, slot map, register offsets and identification constants
`default_nettype none

package soc_periph_pkg;

  //////////////////////////////
  // APB bus widths
  //////////////////////////////
  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;
  // Slot index sits in the top address bits
  localparam int SLOT_W = 2;
  // Byte offset inside one slot
  localparam int SLOT_OFF_W = APB_ADDR_W - SLOT_W;

  // Slot map, slot 3 is left unmapped
  localparam logic [SLOT_W-1:0] SLOT_GPIO = 2'd0;
  localparam logic [SLOT_W-1:0] SLOT_IRQ  = 2'd1;
  localparam logic [SLOT_W-1:0] SLOT_PNP  = 2'd2;
  localparam int SLOT_TOTAL = 3;

  //////////////////////////////
  // Register offsets
  //////////////////////////////
  // GPIO controller
  localparam logic [SLOT_OFF_W-1:0] GPIO_DIR      = 10'h000;
  localparam logic [SLOT_OFF_W-1:0] GPIO_OUT      = 10'h004;
  localparam logic [SLOT_OFF_W-1:0] GPIO_IN       = 10'h008;
  localparam logic [SLOT_OFF_W-1:0] GPIO_IRQ_MASK = 10'h00C;

  // Interrupt controller
  localparam logic [SLOT_OFF_W-1:0] IRQ_PENDING = 10'h000;
  localparam logic [SLOT_OFF_W-1:0] IRQ_ENABLE  = 10'h004;
  localparam logic [SLOT_OFF_W-1:0] IRQ_CLAIM   = 10'h008;

  // Plug-and-play words, device ids follow DEV_BASE one word per slot
  localparam logic [SLOT_OFF_W-1:0] PNP_HWID     = 10'h000;
  localparam logic [SLOT_OFF_W-1:0] PNP_CONFIG   = 10'h004;
  localparam logic [SLOT_OFF_W-1:0] PNP_DEV_BASE = 10'h008;

  //////////////////////////////
  // Identification
  //////////////////////////////
  localparam logic [APB_DATA_W-1:0] HW_ID = 32'h2022_1126;
  localparam logic [15:0] DEV_ID_GPIO = 16'h0060;
  localparam logic [15:0] DEV_ID_IRQ  = 16'h0071;
  localparam logic [15:0] DEV_ID_PNP  = 16'h0089;

  // GPIO width used when the top level is not overridden
  localparam int GPIO_WIDTH_DEFAULT = 12;

endpackage

`default_nettype wire

//--- sources.f
source/soc_periph_pkg.sv
source/apb_slot_decoder.sv
source/apb_gpio.sv
source/irq_ctrl.sv
source/apb_pnp.sv
source/soc_periph.sv
tb/soc_periph_assertions.sv
tb/tb_soc_periph.sv

//--- tb/soc_periph_assertions.sv
// Concurrent APB handshake and interrupt reset checks, bound to the peripheral top
`default_nettype none

module soc_periph_assertions
(
  input wire i_sys_clk,
  input wire i_arst_n,
  input wire i_psel,
  input wire i_penable,
  input wire i_pready,
  input wire i_pslverr,
  input wire i_irq
);

  //////////////////////////////
  // APB response
  //////////////////////////////
  // Ready belongs to the access phase only
  a_ready_in_access: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
    i_pready |-> (i_psel && i_penable))
    else $error("pready raised outside an access cycle");

  // An error is only reported together with ready
  a_err_with_ready: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
    i_pslverr |-> i_pready)
    else $error("pslverr raised without pready");

  // Interrupt line starts quiet once reset is gone
  a_irq_after_reset: assert property (@(posedge i_sys_clk)
    $rose(i_arst_n) |=> !i_irq)
    else $error("irq high one cycle after reset release");

endmodule

bind soc_periph soc_periph_assertions u_assertions (
  .i_sys_clk(i_sys_clk),
  .i_arst_n(i_arst_n),
  .i_psel(i_psel),
  .i_penable(i_penable),
  .i_pready(o_pready),
  .i_pslverr(o_pslverr),
  .i_irq(o_irq)
);

`default_nettype wire

//--- tb/tb_soc_periph.sv
// Directed testbench for the peripheral subsystem with APB master, checks and watchdog
`default_nettype none

module tb_soc_periph;

  localparam int CLK_PERIOD = 8;
  localparam int GPIO_W = 12;
  localparam int RESET_CYCLES = 5;
  // Run limit in clock cycles, well above the length of all tests
  localparam int TIMEOUT_CYCLES = 400;
  // Zero wait states means a few extra cycles already point to a stuck bus
  localparam int READY_LIMIT = 4;
  // Edge interrupt tests use pins 2, 5 and 7
  localparam logic [GPIO_W-1:0] IRQ_BITS = 12'h0A4;

  logic sys_clk = 1'b0;
  logic arst_n;
  logic psel;
  logic penable;
  logic pwrite;
  logic [soc_periph_pkg::APB_ADDR_W-1:0] paddr;
  logic [soc_periph_pkg::APB_DATA_W-1:0] pwdata;
  logic [soc_periph_pkg::APB_DATA_W-1:0] prdata;
  logic pready;
  logic pslverr;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_dir;
  logic irq;
  logic [31:0] lcg_state = 32'd83800;
  // Last values written to the GPIO registers
  logic [GPIO_W-1:0] dir_shadow;
  logic [GPIO_W-1:0] out_shadow;

  soc_periph #(
    .GPIO_WIDTH(GPIO_W)
  ) dut (
    .i_sys_clk(sys_clk),
    .i_arst_n(arst_n),
    .i_psel(psel),
    .i_penable(penable),
    .i_pwrite(pwrite),
    .i_paddr(paddr),
    .i_pwdata(pwdata),
    .o_prdata(prdata),
    .o_pready(pready),
    .o_pslverr(pslverr),
    .i_gpio(gpio_in),
    .o_gpio(gpio_out),
    .o_gpio_dir(gpio_dir),
    .o_irq(irq)
  );

  always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [11:0] slot_addr(input logic [1:0] slot, input logic [9:0] off);
    return {slot, off};
  endfunction

  task automatic abort_run(input string reason);
    $display("Errors found");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run("DUT data output has the wrong value");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run("DUT flag output has the wrong value");
    end
  endtask

  task automatic check_gpio(input string name, input logic [GPIO_W-1:0] got,
                            input logic [GPIO_W-1:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run("GPIO pin output has the wrong value");
    end
  endtask

  // One APB transfer that starts and ends just after a falling edge
  task automatic apb_transfer(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waits;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge sys_clk);
    penable = 1'b1;
    waits = 0;
    // Sample in the low phase away from any clock edge
    #(CLK_PERIOD / 4);
    while (!pready)
    begin
      waits++;
      if (waits > READY_LIMIT)
        abort_run("APB transfer never received pready");
      @(negedge sys_clk);
      #(CLK_PERIOD / 4);
    end
    rdata = prdata;
    err = pslverr;
    @(negedge sys_clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic write_ok(input string name, input logic [11:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_flag({name, " write pslverr"}, err, 1'b0);
  endtask

  task automatic read_expect(input string name, input logic [11:0] addr,
                             input logic [31:0] exp);
    logic [31:0] data;
    logic err;
    apb_read(addr, data, err);
    check_flag({name, " read pslverr"}, err, 1'b0);
    check_data(name, data, exp);
  endtask

  // Failed read answers with an error and zero data
  task automatic read_error(input string name, input logic [11:0] addr);
    logic [31:0] data;
    logic err;
    apb_read(addr, data, err);
    check_flag({name, " read pslverr"}, err, 1'b1);
    check_data({name, " read data"}, data, 32'h0);
  endtask

  // Rejected write also answers with zero data
  task automatic write_error(input string name, input logic [11:0] addr);
    logic [31:0] data;
    logic err;
    apb_transfer(1'b1, addr, next_rand(), data, err);
    check_flag({name, " write pslverr"}, err, 1'b1);
    check_data({name, " write data"}, data, 32'h0);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  task automatic test_pnp_ident();
    read_expect("PNP_HWID", slot_addr(soc_periph_pkg::SLOT_PNP, 10'h000), 32'h2022_1126);
    // Three slots in the low byte and width 12 above
    read_expect("PNP_CONFIG", slot_addr(soc_periph_pkg::SLOT_PNP, 10'h004),
                {16'h0, 8'd12, 8'd3});
    read_expect("DEV_ID_GPIO", slot_addr(soc_periph_pkg::SLOT_PNP, 10'h008),
                {16'h0, soc_periph_pkg::DEV_ID_GPIO});
    read_expect("DEV_ID_IRQ", slot_addr(soc_periph_pkg::SLOT_PNP, 10'h00C),
                {16'h0, soc_periph_pkg::DEV_ID_IRQ});
    read_expect("DEV_ID_PNP", slot_addr(soc_periph_pkg::SLOT_PNP, 10'h010),
                {16'h0, soc_periph_pkg::DEV_ID_PNP});
    write_error("PNP_HWID", slot_addr(soc_periph_pkg::SLOT_PNP, 10'h000));
  endtask

  task automatic test_gpio_regs();
    logic [31:0] word;
    word = next_rand();
    dir_shadow = word[GPIO_W-1:0];
    write_ok("GPIO_DIR", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h000), word);
    word = next_rand();
    out_shadow = word[GPIO_W-1:0];
    write_ok("GPIO_OUT", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h004), word);
    check_gpio("o_gpio_dir", gpio_dir, dir_shadow);
    check_gpio("o_gpio", gpio_out, out_shadow);
    // Only the low GPIO_W bits are stored
    read_expect("GPIO_DIR", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h000), 32'(dir_shadow));
    read_expect("GPIO_OUT", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h004), 32'(out_shadow));
    word = next_rand();
    gpio_in = word[GPIO_W-1:0];
    // Two synchronizer stages before GPIO_IN follows
    repeat (3) @(negedge sys_clk);
    read_expect("GPIO_IN", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h008), 32'(gpio_in));
  endtask

  task automatic test_edge_irq();
    gpio_in = '0;
    repeat (4) @(negedge sys_clk);
    write_ok("IRQ_PENDING", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h000), 32'hFFFF_FFFF);
    write_ok("GPIO_IRQ_MASK", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h00C), 32'(IRQ_BITS));
    write_ok("IRQ_ENABLE", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h004), 32'(IRQ_BITS));
    check_flag("o_irq", irq, 1'b0);
    gpio_in = IRQ_BITS;
    // Pending is set on the fourth edge after the pin change
    repeat (4) @(negedge sys_clk);
    check_flag("o_irq", irq, 1'b1);
    read_expect("IRQ_PENDING", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h000), 32'(IRQ_BITS));
    // Bit 0 lies outside the mask
    gpio_in = IRQ_BITS | 12'h001;
    repeat (4) @(negedge sys_clk);
    read_expect("IRQ_PENDING", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h000), 32'(IRQ_BITS));
  endtask

  task automatic test_claim_order();
    // Lowest index is claimed first and each id is the bit index plus one
    read_expect("IRQ_CLAIM", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h008), 32'd3);
    read_expect("IRQ_CLAIM", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h008), 32'd6);
    check_flag("o_irq", irq, 1'b1);
    read_expect("IRQ_CLAIM", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h008), 32'd8);
    check_flag("o_irq", irq, 1'b0);
    read_expect("IRQ_CLAIM", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h008), 32'd0);
    read_expect("IRQ_PENDING", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h000), 32'h0);
    // Fresh edges on the same pins
    gpio_in = '0;
    repeat (4) @(negedge sys_clk);
    gpio_in = IRQ_BITS;
    repeat (4) @(negedge sys_clk);
    write_ok("IRQ_PENDING", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h000), 32'h0000_0024);
    read_expect("IRQ_PENDING", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h000), 32'h0000_0080);
    check_flag("o_irq", irq, 1'b1);
    // Pending bit 7 stays quiet and unclaimable while its enable is off
    write_ok("IRQ_ENABLE", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h004), 32'h0000_0024);
    check_flag("o_irq", irq, 1'b0);
    read_expect("IRQ_CLAIM", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h008), 32'd0);
    write_ok("IRQ_ENABLE", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h004), 32'(IRQ_BITS));
    check_flag("o_irq", irq, 1'b1);
    write_ok("IRQ_PENDING", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h000), 32'h0000_0080);
    check_flag("o_irq", irq, 1'b0);
  endtask

  task automatic test_decode_errors();
    read_error("slot 3", slot_addr(2'd3, 10'h000));
    write_error("slot 3", slot_addr(2'd3, 10'h000));
    read_error("GPIO offset 0x10", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h010));
    write_error("GPIO offset 0x10", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h010));
    read_error("IRQ offset 0x0C", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h00C));
    write_error("IRQ offset 0x0C", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h00C));
    // Registers keep their earlier contents
    read_expect("GPIO_DIR", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h000), 32'(dir_shadow));
    read_expect("GPIO_OUT", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h004), 32'(out_shadow));
    read_expect("GPIO_IRQ_MASK", slot_addr(soc_periph_pkg::SLOT_GPIO, 10'h00C), 32'(IRQ_BITS));
    read_expect("IRQ_ENABLE", slot_addr(soc_periph_pkg::SLOT_IRQ, 10'h004), 32'(IRQ_BITS));
    check_gpio("o_gpio_dir", gpio_dir, dir_shadow);
    check_gpio("o_gpio", gpio_out, out_shadow);
  endtask

  //////////////////////////////
  // Run control
  //////////////////////////////
  initial
  begin
    arst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    gpio_in = '0;
    repeat (RESET_CYCLES) @(negedge sys_clk);
    arst_n = 1'b1;
    @(negedge sys_clk);
    check_flag("o_irq", irq, 1'b0);
    check_gpio("o_gpio_dir", gpio_dir, '0);
    check_gpio("o_gpio", gpio_out, '0);
    test_pnp_ident();
    test_gpio_regs();
    test_edge_irq();
    test_claim_order();
    test_decode_errors();
    $display("No errors");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire
